/* Makefile */
TOP = tb_core_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* axi_lite_read_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_ctrl_defs.svh"

module axi_lite_read_port (
    input  wire                       S_AXI_ACLK,
    input  wire                       cache_slv_reg1,
    input  wire core_ctrl_pkg::addr_t S_AXI_ARADDR,
    input  wire                       S_AXI_ARVALID,
    output logic                      S_AXI_ARREADY,
    output core_ctrl_pkg::word_t      S_AXI_RDATA,
    output logic [1:0]                S_AXI_RRESP,
    output logic                      S_AXI_RVALID,
    input  wire                       S_AXI_RREADY,
    input  wire core_ctrl_pkg::word_t run_word,
    input  wire core_ctrl_pkg::snap_t snap
);
    import core_ctrl_pkg::*;

    rd_state_e state;
    addr_t     rd_addr;
    addr_t     gpr_off;
    word_t     rd_word;

    // ---------------------------------------------------------------------------
    // Channel FSM
    // ---------------------------------------------------------------------------
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg1)
    begin
        if (cache_slv_reg1)
        begin
            state <= RD_IDLE;
        end
        else
        begin
            case (state)
                RD_IDLE:
                begin
                    if (S_AXI_ARVALID)
                    begin
                        state <= RD_ACK;
                    end
                end
                // Address accepted, data registered on the way out
                RD_ACK:
                begin
                    state <= RD_DATA;
                end
                // Hold data until the host takes it
                RD_DATA:
                begin
                    if (S_AXI_RREADY)
                    begin
                        state <= RD_IDLE;
                    end
                end
                default:
                begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // Address capture and data register
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (state == RD_IDLE && S_AXI_ARVALID)
        begin
            rd_addr <= S_AXI_ARADDR;
        end
        if (state == RD_ACK)
        begin
            S_AXI_RDATA <= rd_word;
        end
    end

    // ---------------------------------------------------------------------------
    // Address decode
    // ---------------------------------------------------------------------------
    always_comb
    begin
        gpr_off = rd_addr - `CC_ADDR_GPR_BASE;
        // Unmapped addresses read 0
        rd_word = '0;
        if (rd_addr == `CC_ADDR_RUN)
        begin
            rd_word = run_word;
        end
        else if (rd_addr == `CC_ADDR_PC)
        begin
            rd_word = snap[`CC_NUM_GPR];
        end
        else if (rd_addr >= `CC_ADDR_GPR_BASE &&
                 gpr_off < addr_t'(4 * `CC_NUM_GPR) && gpr_off[1:0] == 2'b00)
        begin
            // Word offset selects the general register
            rd_word = snap[{1'b0, gpr_off[6:2]}];
        end
    end

    assign S_AXI_ARREADY = (state == RD_ACK);
    assign S_AXI_RVALID  = (state == RD_DATA);
    assign S_AXI_RRESP   = `CC_RESP_OKAY;

    // Stalled read keeps its data
    a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg1)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));

endmodule

`default_nettype wire

/* axi_lite_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_ctrl_defs.svh"

module axi_lite_write_port (
    input  wire                       S_AXI_ACLK,
    input  wire                       cache_slv_reg1,
    input  wire core_ctrl_pkg::addr_t S_AXI_AWADDR,
    input  wire                       S_AXI_AWVALID,
    output logic                      S_AXI_AWREADY,
    input  wire core_ctrl_pkg::word_t S_AXI_WDATA,
    input  wire                       S_AXI_WVALID,
    output logic                      S_AXI_WREADY,
    output logic [1:0]                S_AXI_BRESP,
    output logic                      S_AXI_BVALID,
    input  wire                       S_AXI_BREADY,
    output logic                      wr_en,
    output core_ctrl_pkg::addr_t      wr_addr,
    output core_ctrl_pkg::word_t      wr_data
);
    import core_ctrl_pkg::*;

    wr_state_e state;
    logic      accept;

    // ---------------------------------------------------------------------------
    // Channel FSM
    // ---------------------------------------------------------------------------
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg1)
    begin
        if (cache_slv_reg1)
        begin
            state <= WR_IDLE;
        end
        else
        begin
            case (state)
                // Wait for address and data together
                WR_IDLE:
                begin
                    if (S_AXI_AWVALID && S_AXI_WVALID)
                    begin
                        state <= WR_ACK;
                    end
                end
                // Ready pulse lasts exactly one cycle
                WR_ACK:
                begin
                    state <= WR_RESP;
                end
                // Held here by BREADY back-pressure
                WR_RESP:
                begin
                    if (S_AXI_BREADY)
                    begin
                        state <= WR_IDLE;
                    end
                end
                default:
                begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    // Capture address and data as the transfer starts
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (state == WR_IDLE && S_AXI_AWVALID && S_AXI_WVALID)
        begin
            wr_addr <= S_AXI_AWADDR;
            wr_data <= S_AXI_WDATA;
        end
    end

    // Both readys and the register strobe share the ack cycle
    assign accept        = (state == WR_ACK);
    assign S_AXI_AWREADY = accept;
    assign S_AXI_WREADY  = accept;
    assign wr_en         = accept;

    // Writes always complete with OKAY
    assign S_AXI_BVALID = (state == WR_RESP);
    assign S_AXI_BRESP  = `CC_RESP_OKAY;

    // Ack lasts one cycle and the response follows on the next edge
    a_ack_then_resp: assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg1)
        S_AXI_AWREADY |=> S_AXI_BVALID && !S_AXI_AWREADY);

    // Response is held until the host takes it
    a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg1)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
core_ctrl_pkg.sv
axi_lite_write_port.sv
axi_lite_read_port.sv
exec_ctrl_regs.sv
core_snapshot.sv
exec_gate.sv
core_ctrl_top.sv
tb_core_ctrl.sv

/* core_ctrl_defs.svh */
`ifndef CORE_CTRL_DEFS_SVH
`define CORE_CTRL_DEFS_SVH

// Bus widths
`define CC_DATA_W 32
`define CC_ADDR_W 16

// Core register file size
`define CC_NUM_GPR 32
// General registers plus the PC
`define CC_SNAP_WORDS 33

// ---------------------------------------------------------------------------
// Address map
// ---------------------------------------------------------------------------
`define CC_ADDR_RUN 16'h0000
`define CC_ADDR_STEP 16'h0004
// Register n sits at base plus 4*n
`define CC_ADDR_GPR_BASE 16'h1000
`define CC_ADDR_PC 16'h1080

// AXI response code
`define CC_RESP_OKAY 2'b00

`endif

/* core_ctrl_pkg.sv */
`default_nettype none

`include "core_ctrl_defs.svh"

package core_ctrl_pkg;

    // One bus word and one bus address
    typedef logic [`CC_DATA_W-1:0] word_t;
    typedef logic [`CC_ADDR_W-1:0] addr_t;

    // All core registers in one vector, index 32 holds the PC
    typedef logic [`CC_SNAP_WORDS-1:0][`CC_DATA_W-1:0] snap_t;

    // Write channel states
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ACK,
        WR_RESP
    } wr_state_e;

    // Read channel states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACK,
        RD_DATA
    } rd_state_e;

endpackage

`default_nettype wire

/* core_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_ctrl_defs.svh"

module core_ctrl_top (
    input  wire                       S_AXI_ACLK,
    input  wire                       cache_slv_reg1,
    input  wire                       core_clk,
    input  wire [`CC_ADDR_W-1:0]      S_AXI_AWADDR,
    input  wire                       S_AXI_AWVALID,
    output wire                       S_AXI_AWREADY,
    input  wire [`CC_DATA_W-1:0]      S_AXI_WDATA,
    input  wire                       S_AXI_WVALID,
    output wire                       S_AXI_WREADY,
    output wire [1:0]                 S_AXI_BRESP,
    output wire                       S_AXI_BVALID,
    input  wire                       S_AXI_BREADY,
    input  wire [`CC_ADDR_W-1:0]      S_AXI_ARADDR,
    input  wire                       S_AXI_ARVALID,
    output wire                       S_AXI_ARREADY,
    output wire [`CC_DATA_W-1:0]      S_AXI_RDATA,
    output wire [1:0]                 S_AXI_RRESP,
    output wire                       S_AXI_RVALID,
    input  wire                       S_AXI_RREADY,
    input  wire core_ctrl_pkg::snap_t core_regs,
    output wire                       cexec
);

    // Register write strobe from the write channel
    wire                                     wr_en;
    wire [`CC_ADDR_W-1:0]                    wr_addr;
    wire [`CC_DATA_W-1:0]                    wr_data;
    // Control words and sampled core state
    wire [`CC_DATA_W-1:0]                    run_word;
    wire [`CC_DATA_W-1:0]                    step_word;
    wire [`CC_SNAP_WORDS-1:0][`CC_DATA_W-1:0] snap;

    axi_lite_write_port axi_lite_write_port_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .cache_slv_reg1(cache_slv_reg1),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    axi_lite_read_port axi_lite_read_port_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .cache_slv_reg1(cache_slv_reg1),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .run_word      (run_word),
        .snap          (snap)
    );

    exec_ctrl_regs exec_ctrl_regs_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .cache_slv_reg1(cache_slv_reg1),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .run_word      (run_word),
        .step_word     (step_word)
    );

    core_snapshot core_snapshot_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .cache_slv_reg1(cache_slv_reg1),
        .core_regs     (core_regs),
        .snap          (snap)
    );

    exec_gate exec_gate_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .cache_slv_reg1(cache_slv_reg1),
        .core_clk      (core_clk),
        .run_word      (run_word),
        .step_word     (step_word),
        .cexec         (cexec)
    );

endmodule

`default_nettype wire

/* core_snapshot.sv */
`timescale 1ns/1ps
`default_nettype none

module core_snapshot (
    input  wire                       S_AXI_ACLK,
    input  wire                       cache_slv_reg1,
    input  wire core_ctrl_pkg::snap_t core_regs,
    output core_ctrl_pkg::snap_t      snap
);
    import core_ctrl_pkg::*;

    // First sampling stage of the core values
    snap_t stage0;

    // Two flops per bit bring the core values into the bus clock domain
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg1)
    begin
        if (cache_slv_reg1)
        begin
            stage0 <= '0;
            snap   <= '0;
        end
        else
        begin
            stage0 <= core_regs;
            snap   <= stage0;
        end
    end

endmodule

`default_nettype wire

/* exec_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_ctrl_defs.svh"

module exec_ctrl_regs (
    input  wire                       S_AXI_ACLK,
    input  wire                       cache_slv_reg1,
    input  wire                       wr_en,
    input  wire core_ctrl_pkg::addr_t wr_addr,
    input  wire core_ctrl_pkg::word_t wr_data,
    output core_ctrl_pkg::word_t      run_word,
    output core_ctrl_pkg::word_t      step_word
);

    // ---------------------------------------------------------------------------
    // Run register
    // ---------------------------------------------------------------------------
    // Holds its value until the host writes it again
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg1)
    begin
        if (cache_slv_reg1)
        begin
            run_word <= '0;
        end
        else if (wr_en && wr_addr == `CC_ADDR_RUN)
        begin
            run_word <= wr_data;
        end
    end

    // ---------------------------------------------------------------------------
    // Step register
    // ---------------------------------------------------------------------------
    // Written value shows for one cycle, then back to 0
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg1)
    begin
        if (cache_slv_reg1)
        begin
            step_word <= '0;
        end
        else if (wr_en && wr_addr == `CC_ADDR_STEP)
        begin
            step_word <= wr_data;
        end
        else
        begin
            step_word <= '0;
        end
    end

endmodule

`default_nettype wire

/* exec_gate.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_gate (
    input  wire                       S_AXI_ACLK,
    input  wire                       cache_slv_reg1,
    input  wire                       core_clk,
    input  wire core_ctrl_pkg::word_t run_word,
    input  wire core_ctrl_pkg::word_t step_word,
    output logic                      cexec
);

    logic       run_flag;
    logic       step_flag;
    // cexec seen back in the bus clock domain
    logic [1:0] cexec_sync;

    // ---------------------------------------------------------------------------
    // Request flags, bus clock domain
    // ---------------------------------------------------------------------------
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg1)
    begin
        if (cache_slv_reg1)
        begin
            run_flag   <= 1'b0;
            step_flag  <= 1'b0;
            cexec_sync <= 2'b00;
        end
        else
        begin
            cexec_sync <= {cexec_sync[0], cexec};
            // Run holds the flag for as long as it is nonzero
            if (run_word != '0)
            begin
                run_flag <= 1'b1;
            end
            else if (cexec_sync[1])
            begin
                run_flag <= 1'b0;
            end
            // Step drops once the core has seen it
            if (step_word != '0)
            begin
                step_flag <= 1'b1;
            end
            else if (cexec_sync[1])
            begin
                step_flag <= 1'b0;
            end
        end
    end

    // Execute enable on the core clock
    always_ff @(posedge core_clk or posedge cache_slv_reg1)
    begin
        if (cache_slv_reg1)
        begin
            cexec <= 1'b0;
        end
        else
        begin
            cexec <= run_flag | step_flag;
        end
    end

    // Only a step write raises the step flag
    a_step_source: assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg1)
        !step_flag && step_word == '0 |=> !step_flag);

endmodule

`default_nettype wire

/* tb_core_ctrl_tests.svh */
`ifndef TB_CORE_CTRL_TESTS_SVH
`define TB_CORE_CTRL_TESTS_SVH

// --------------------------------------------------------------------------
// Directed tests
// --------------------------------------------------------------------------
// Run register reads 0 and the core is stopped
task automatic reset_state_test();
    logic [31:0] data;
    logic [1:0]  resp;
    int          start_errors;
    start_errors = error_count;
    axi_read(`CC_ADDR_RUN, data, resp);
    check("run register", data, 32'h0);
    check("S_AXI_RRESP", 32'(resp), 32'(`CC_RESP_OKAY));
    check("cexec", 32'(cexec), 32'h0);
    finish_test("reset_state", start_errors);
endtask

// Nonzero run holds cexec high
task automatic run_hold_test();
    logic [31:0] run_value;
    logic [31:0] data;
    logic [1:0]  resp;
    int          start_errors;
    int          highs;
    start_errors = error_count;
    run_value = next_random() | 32'h1;
    axi_write(`CC_ADDR_RUN, run_value, resp);
    check("S_AXI_BRESP", 32'(resp), 32'(`CC_RESP_OKAY));
    axi_read(`CC_ADDR_RUN, data, resp);
    check("run register", data, run_value);
    check("S_AXI_RRESP", 32'(resp), 32'(`CC_RESP_OKAY));
    wait_for_cexec(1'b1);
    // Level must not drop while run stays set
    highs = 0;
    repeat (20)
    begin
        @(posedge aclk);
        if (cexec)
        begin
            highs = highs + 1;
        end
    end
    check("cexec high cycles", 32'(highs), 32'd20);
    finish_test("run_hold", start_errors);
endtask

// Clearing run stops the core
task automatic run_clear_test();
    logic [31:0] data;
    logic [1:0]  resp;
    int          start_errors;
    start_errors = error_count;
    axi_write(`CC_ADDR_RUN, 32'h0, resp);
    check("S_AXI_BRESP", 32'(resp), 32'(`CC_RESP_OKAY));
    wait_for_cexec(1'b0);
    axi_read(`CC_ADDR_RUN, data, resp);
    check("run register", data, 32'h0);
    finish_test("run_clear", start_errors);
endtask

// One step gives one cexec pulse, step is write only
task automatic single_step_test();
    logic [31:0] data;
    logic [1:0]  resp;
    int          start_errors;
    start_errors = error_count;
    axi_write(`CC_ADDR_STEP, next_random() | 32'h1, resp);
    check("S_AXI_BRESP", 32'(resp), 32'(`CC_RESP_OKAY));
    wait_for_cexec(1'b1);
    wait_for_cexec(1'b0);
    axi_read(`CC_ADDR_STEP, data, resp);
    check("step register", data, 32'h0);
    finish_test("single_step", start_errors);
endtask

// Core registers show up at their map addresses
task automatic snapshot_read_test();
    logic [31:0] driven [0:`CC_SNAP_WORDS-1];
    logic [31:0] data;
    logic [31:0] r;
    logic [1:0]  resp;
    int          start_errors;
    int          i;
    int          n;
    start_errors = error_count;
    @(posedge aclk);
    for (i = 0; i < `CC_SNAP_WORDS; i++)
    begin
        driven[i]    = next_random();
        core_regs[i] <= driven[i];
    end
    // Well past the two sampling stages
    repeat (6) @(posedge aclk);
    for (i = 0; i < 4; i++)
    begin
        r = next_random();
        n = int'(r[4:0]);
        axi_read(`CC_ADDR_GPR_BASE + 16'(4 * n), data, resp);
        check($sformatf("gpr %0d", n), data, driven[n]);
        check("S_AXI_RRESP", 32'(resp), 32'(`CC_RESP_OKAY));
    end
    axi_read(`CC_ADDR_PC, data, resp);
    check("pc", data, driven[`CC_NUM_GPR]);
    finish_test("snapshot_read", start_errors);
endtask

// Holes in the map read 0 and ignore writes
task automatic unmapped_access_test();
    logic [15:0] holes [0:3];
    logic [31:0] run_value;
    logic [31:0] data;
    logic [1:0]  resp;
    int          start_errors;
    int          i;
    start_errors = error_count;
    holes[0] = 16'h0008;
    // Misaligned inside the register window
    holes[1] = 16'h1002;
    // Just past the PC
    holes[2] = 16'h1084;
    holes[3] = 16'hfffc;
    for (i = 0; i < 4; i++)
    begin
        axi_read(holes[i], data, resp);
        check($sformatf("read of %h", holes[i]), data, 32'h0);
        check("S_AXI_RRESP", 32'(resp), 32'(`CC_RESP_OKAY));
    end
    run_value = next_random() | 32'h1;
    axi_write(`CC_ADDR_RUN, run_value, resp);
    axi_write(holes[0], ~run_value, resp);
    check("S_AXI_BRESP", 32'(resp), 32'(`CC_RESP_OKAY));
    axi_read(`CC_ADDR_RUN, data, resp);
    check("run register", data, run_value);
    // Leave the core stopped
    axi_write(`CC_ADDR_RUN, 32'h0, resp);
    wait_for_cexec(1'b0);
    finish_test("unmapped_access", start_errors);
endtask

`endif

/* tb_core_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_ctrl_defs.svh"

module tb_core_ctrl;

    // Handshake and cexec waits give up after this many bus cycles
    localparam int WAIT_LIMIT = 100;

    logic                                     aclk;
    logic                                     reset;
    logic                                     core_clk;
    logic [`CC_ADDR_W-1:0]                    awaddr;
    logic                                     awvalid;
    wire                                      awready;
    logic [`CC_DATA_W-1:0]                    wdata;
    logic                                     wvalid;
    wire                                      wready;
    wire  [1:0]                               bresp;
    wire                                      bvalid;
    logic                                     bready;
    logic [`CC_ADDR_W-1:0]                    araddr;
    logic                                     arvalid;
    wire                                      arready;
    wire  [`CC_DATA_W-1:0]                    rdata;
    wire  [1:0]                               rresp;
    wire                                      rvalid;
    logic                                     rready;
    logic [`CC_SNAP_WORDS-1:0][`CC_DATA_W-1:0] core_regs;
    wire                                      cexec;

    // Run bookkeeping
    int          error_count;
    int          tests_run;
    int          tests_bad;
    logic [31:0] lcg_state;

    core_ctrl_top core_ctrl_top_i (
        .S_AXI_ACLK    (aclk),
        .cache_slv_reg1(reset),
        .core_clk      (core_clk),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (awready),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (wready),
        .S_AXI_BRESP   (bresp),
        .S_AXI_BVALID  (bvalid),
        .S_AXI_BREADY  (bready),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready),
        .S_AXI_RDATA   (rdata),
        .S_AXI_RRESP   (rresp),
        .S_AXI_RVALID  (rvalid),
        .S_AXI_RREADY  (rready),
        .core_regs     (core_regs),
        .cexec         (cexec)
    );

    // --------------------------------------------------------------------------
    // Clocks
    // --------------------------------------------------------------------------
    // Bus clock, 20 ns
    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #10 aclk = ~aclk;
        end
    end

    // Core clock, 30 ns, its rising edges never meet the bus clock's
    initial
    begin
        core_clk = 1'b0;
        forever
        begin
            #15 core_clk = ~core_clk;
        end
    end

    // --------------------------------------------------------------------------
    // Helpers
    // --------------------------------------------------------------------------
    // LCG step, numerical recipes constants
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Compare and count a mismatch
    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("mismatch %s got %h expected %h", name, got, expected);
            error_count = error_count + 1;
        end
    endtask

    // One summary line per test
    task automatic finish_test(input string name, input int start_errors);
        tests_run = tests_run + 1;
        if (error_count == start_errors)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_bad = tests_bad + 1;
            $display("test %s: %0d errors", name, error_count - start_errors);
        end
    endtask

    // --------------------------------------------------------------------------
    // AXI4-Lite bus tasks
    // --------------------------------------------------------------------------
    // Outputs are sampled at the rising edge, before the DUT updates
    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        resp = 2'b11;
        @(posedge aclk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        // Address and data accepted together
        waited = 0;
        @(posedge aclk);
        while (!awready && waited < WAIT_LIMIT)
        begin
            @(posedge aclk);
            waited = waited + 1;
        end
        if (!awready)
        begin
            $display("timeout waiting for AWREADY on write to %h", addr);
            error_count = error_count + 1;
        end
        // WREADY rises in the same cycle as AWREADY
        check("S_AXI_WREADY", 32'(wready), 32'h1);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        // Response channel
        waited = 0;
        @(posedge aclk);
        while (!bvalid && waited < WAIT_LIMIT)
        begin
            @(posedge aclk);
            waited = waited + 1;
        end
        if (bvalid)
        begin
            resp = bresp;
        end
        else
        begin
            $display("timeout waiting for BVALID on write to %h", addr);
            error_count = error_count + 1;
        end
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int waited;
        data = 32'hdeadbeef;
        resp = 2'b11;
        @(posedge aclk);
        araddr  <= addr;
        arvalid <= 1'b1;
        waited  = 0;
        @(posedge aclk);
        while (!arready && waited < WAIT_LIMIT)
        begin
            @(posedge aclk);
            waited = waited + 1;
        end
        if (!arready)
        begin
            $display("timeout waiting for ARREADY on read of %h", addr);
            error_count = error_count + 1;
        end
        arvalid <= 1'b0;
        rready  <= 1'b1;
        // Data channel
        waited = 0;
        @(posedge aclk);
        while (!rvalid && waited < WAIT_LIMIT)
        begin
            @(posedge aclk);
            waited = waited + 1;
        end
        if (rvalid)
        begin
            data = rdata;
            resp = rresp;
        end
        else
        begin
            $display("timeout waiting for RVALID on read of %h", addr);
            error_count = error_count + 1;
        end
        rready <= 1'b0;
    endtask

    // Wait for cexec to reach a level
    task automatic wait_for_cexec(input logic level);
        int waited;
        waited = 0;
        @(posedge aclk);
        while (cexec !== level && waited < WAIT_LIMIT)
        begin
            @(posedge aclk);
            waited = waited + 1;
        end
        if (cexec !== level)
        begin
            $display("timeout waiting for cexec to become %0d", level);
            error_count = error_count + 1;
        end
    endtask

    `include "tb_core_ctrl_tests.svh"

    // --------------------------------------------------------------------------
    // Main sequence
    // --------------------------------------------------------------------------
    initial
    begin
        error_count = 0;
        tests_run   = 0;
        tests_bad   = 0;
        lcg_state   = 32'hd64f29b8;
        // Idle bus, core registers cleared
        reset     = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        core_regs = '0;
        repeat (5) @(posedge aclk);
        reset <= 1'b0;

        reset_state_test();
        run_hold_test();
        run_clear_test();
        single_step_test();
        snapshot_read_test();
        unmapped_access_test();

        $display("tests run %0d, tests with errors %0d, failing checks %0d",
                 tests_run, tests_bad, error_count);
        if (error_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
